//--- bench/scroll_golden.txt
# test pages hscr vscr vrender col expected
# pages, hscr, vscr and expected pixel in hex, test, vrender and col in decimal
2 5361 0000 0000 20 0 6a5
2 5361 0000 0000 20 3 6a2
2 5361 0000 0000 20 7 6a5
2 5361 0000 0000 20 13 6a8
3 5361 01e5 0000 20 0 0c8
3 5361 01e5 0000 20 1 0ca
3 5361 01e5 0000 20 25 0ea
3 5361 01e5 0000 20 26 0ef
3 5361 01e5 0000 20 27 2a5
4 5361 01f0 00f3 20 0 63d
4 5361 01f0 00f3 20 15 64f
4 5361 01f0 00f3 20 16 202
4 5361 01f0 00f3 20 22 205
5 5361 0000 0000 20 1 6a7
5 5361 0000 0000 20 6 6a2
5 5361 0000 0000 20 12 6af
5 5361 0000 0000 20 13 6a8
6 5361 0000 0000 20 1 000
6 5361 0000 0000 20 6 000
6 5361 0000 0000 20 12 000
6 5361 0000 0000 20 13 000

//--- bench/scroll_layer_tb.sv
`timescale 1ns/1ps
// testbench for the scroll layer
// paths are relative to the project root
// register values, lines, probe columns and expected pixels come from
// bench/scroll_golden.txt; test 5 rewrites hscr mid-line and test 6 only reads
// rom latency is 0..7 clk from a seeded lfsr and must not change pixels
module scroll_layer_tb
    import video_pkg::*;
    import regs_pkg::*;
();

    localparam int line_w      = 256;
    localparam int num_tests   = 6;   // apb test plus the golden tests
    localparam int shadow_test = 5;
    localparam int erase_test  = 6;

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [apb_aw-1:0]      paddr;
    logic [reg_w-1:0]       pwdata;
    logic [reg_w-1:0]       prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   lhbl;
    logic [pos_w-1:0]       vrender;
    logic [pos_w-1:0]       hdump;
    logic [pxl_w-1:0]       pxl;
    logic                   map_req;
    logic [map_addr_w-1:0]  map_addr;
    logic                   map_ok;
    logic [map_dw-1:0]      map_data;
    logic                   tile_req;
    logic [tile_addr_w-1:0] tile_addr;
    logic                   tile_ok;
    logic [tile_dw-1:0]     tile_data;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          tests;

    // golden rows
    int          g_id[$];
    logic [15:0] g_pages[$];
    logic [15:0] g_hscr[$];
    logic [15:0] g_vscr[$];
    int          g_line[$];
    int          g_col[$];
    logic [15:0] g_exp[$];

    scroll_layer scroll_layer_inst (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .lhbl      (lhbl),
        .vrender   (vrender),
        .hdump     (hdump),
        .pxl       (pxl),
        .map_req   (map_req),
        .map_addr  (map_addr),
        .map_ok    (map_ok),
        .map_data  (map_data),
        .tile_req  (tile_req),
        .tile_addr (tile_addr),
        .tile_ok   (tile_ok),
        .tile_data (tile_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);  // one step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // rom contents
    function automatic logic [15:0] map_word(input logic [map_addr_w-1:0] a);
        map_word = 16'(32'(a) * 32'd37 + 32'd5);
    endfunction

    function automatic logic [31:0] tile_word(input logic [tile_addr_w-1:0] a);
        logic [15:0] m;
        m = 16'(32'(a) * 32'h9e37 + 32'd1);
        tile_word = {m, m};  // low half repeated so the planes fill bytes 0..2
    endfunction

    // one model serves both rom ports as they are never busy together
    initial begin : rom_model
        int d;
        lfsr      = 32'd95389;
        map_ok    = 1'b0;
        map_data  = '0;
        tile_ok   = 1'b0;
        tile_data = '0;
        forever begin
            @(negedge clk);
            map_ok  = 1'b0;  // ok lasts one clk
            tile_ok = 1'b0;
            if (map_req) begin
                take_bits(3, d);
                repeat (d) @(negedge clk);
                map_data = map_word(map_addr);
                map_ok   = 1'b1;
            end else if (tile_req) begin
                take_bits(3, d);
                repeat (d) @(negedge clk);
                tile_data = tile_word(tile_addr);
                tile_ok   = 1'b1;
            end
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp)
        else begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [15:0] data,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;  // setup
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;  // write lands on the next rising edge
        @(negedge clk);
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [apb_aw-1:0] addr, output logic [15:0] data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data    = prdata;  // combinational during access
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic pulse_lhbl();
        @(negedge clk);
        lhbl = 1'b0;
        repeat (2) @(negedge clk);  // busy is up by now
        lhbl = 1'b1;
    endtask

    // poll status until the render is done
    task automatic wait_idle();
        logic [15:0] st;
        logic        err;
        st = 16'h0001;
        while (st[status_busy_bit] == 1'b1)
            apb_read(reg_status, st, err);
    endtask

    task automatic read_pixel(input int c, output logic [pxl_w-1:0] v);
        @(negedge clk);
        hdump = 9'(c);
        @(negedge clk);
        v     = pxl;
        hdump = 9'h1ff;  // park past the line so nothing is cleared
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        int          id;
        int          ln;
        int          c;
        logic [15:0] pg;
        logic [15:0] hs;
        logic [15:0] vs;
        logic [15:0] ex;
        string       text;
        fd = $fopen("bench/scroll_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/scroll_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 0 && text[0] != "#") begin  // skip comment lines
                    n = $sscanf(text, "%d %h %h %h %d %d %h", id, pg, hs, vs, ln, c, ex);
                    if (n == 7) begin
                        g_id.push_back(id);
                        g_pages.push_back(pg);
                        g_hscr.push_back(hs);
                        g_vscr.push_back(vs);
                        g_line.push_back(ln);
                        g_col.push_back(c);
                        g_exp.push_back(ex);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // reset values, status write and holes
    task automatic apb_test();
        int          err0;
        logic        err;
        logic [15:0] rd;
        err0 = errors;
        apb_read(reg_pages, rd, err);
        check_value("prdata pages", int'(rd), 0);
        apb_read(reg_hscr, rd, err);
        check_value("prdata hscr", int'(rd), 0);
        apb_read(reg_vscr, rd, err);
        check_value("prdata vscr", int'(rd), 0);
        apb_read(reg_status, rd, err);
        check_value("prdata status", int'(rd), 0);
        check_value("pready", int'(pready), 1);
        apb_write(reg_status, 16'h0001, err);
        check_value("pslverr on status write", int'(err), 1);
        apb_write(4'd2, 16'h1234, err);
        check_value("pslverr on unmapped write", int'(err), 1);
        apb_read(4'd14, rd, err);
        check_value("pslverr on unmapped read", int'(err), 1);
        apb_read(reg_hscr, rd, err);
        check_value("pslverr on hscr read", int'(err), 0);
        check_value("prdata hscr", int'(rd), 0);
        tests++;
        $display("test 1: apb registers, %0d errors", errors - err0);
    endtask

    task automatic run_group(input int first, input int last);
        int               err0;
        logic             err;
        logic [15:0]      rd;
        logic [pxl_w-1:0] got;
        err0 = errors;
        if (g_id[first] != erase_test) begin
            apb_write(reg_pages, g_pages[first], err);
            apb_write(reg_hscr, g_hscr[first], err);
            apb_write(reg_vscr, g_vscr[first], err);
            apb_read(reg_pages, rd, err);
            check_value("prdata pages", int'(rd), int'(g_pages[first]));
            apb_read(reg_hscr, rd, err);
            check_value("prdata hscr", int'(rd), int'(g_hscr[first]));
            apb_read(reg_vscr, rd, err);
            check_value("prdata vscr", int'(rd), int'(g_vscr[first]));
            vrender = 9'(g_line[first]);
            pulse_lhbl();
            if (g_id[first] == shadow_test) begin
                apb_read(reg_status, rd, err);
                checks++;
                assert (rd[status_busy_bit] == 1'b1)
                else begin
                    $display("status busy bit clear while the line was rendering");
                    errors++;
                end
                apb_write(reg_hscr, g_hscr[first] ^ 16'h0155, err);  // lands on next line
            end
            wait_idle();
            pulse_lhbl();  // swap so the rendered half goes on display
            wait_idle();
        end
        for (int k = first; k <= last; k++) begin
            read_pixel(g_col[k], got);
            check_value($sformatf("pxl col %0d", g_col[k]), int'(got), int'(g_exp[k]));
        end
        tests++;
        $display("test %0d: %0d probes, %0d errors", g_id[first], last - first + 1,
                 errors - err0);
    endtask

    initial begin : main
        int idx;
        int last;
        checks  = 0;
        errors  = 0;
        tests   = 0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lhbl    = 1'b1;
        vrender = '0;
        hdump   = 9'h1ff;
        load_golden();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        apb_test();
        if (g_id.size() == 0) begin
            $display("golden file holds no test rows");
            errors++;
        end
        idx = 0;
        while (idx < g_id.size()) begin
            last = idx;
            while (last + 1 < g_id.size() && g_id[last + 1] == g_id[idx])
                last++;
            run_group(idx, last);
            idx = last + 1;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // each test renders two lines of line_w pixels plus rom latency
    initial begin : watchdog
        repeat (num_tests * line_w * 40) @(posedge clk);
        $display("run timed out after %0d cycles", num_tests * line_w * 40);
        $display("Test failed");
        $finish;
    end

endmodule

//--- hdl/line_buffer.sv
`timescale 1ns/1ps
// ping-pong line store, one half rendered while the other is shown
// halves swap on line_start; reads return the previous line's half
// pxl follows hdump by one clk and the entry read is cleared, so a
// second readout without a new render shows zero
// columns at or beyond line_w read as zero and are left untouched
module line_buffer
    import video_pkg::*;
#(
    parameter int line_w = 256,
    parameter int buf_aw = 9,
    parameter int dw     = 11
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              line_start,
    input  logic              wr_en,
    input  logic [buf_aw-1:0] wr_addr,
    input  logic [dw-1:0]     wr_data,
    input  logic [pos_w-1:0]  hdump,
    output logic [dw-1:0]     pxl
);

    logic              sel;     // half being rendered
    logic              rd_sel;  // half the current pxl came from
    logic              rd_hit;
    logic [buf_aw-1:0] rd_a;

    assign rd_hit = int'(hdump) < line_w;
    assign rd_a   = buf_aw'(hdump);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel    <= 1'b0;
            rd_sel <= 1'b1;
        end else begin
            if (line_start)
                sel <= ~sel;
            rd_sel <= ~sel;  // display half at the read
        end
    end

    for (genvar h = 0; h < 2; h++) begin : g_half
        logic [dw-1:0] mem [2**buf_aw];
        logic [dw-1:0] q;

        always_ff @(posedge clk) begin
            if (sel == 1'(h)) begin
                if (wr_en)
                    mem[wr_addr] <= wr_data;      // render side
            end else begin
                q <= rd_hit ? mem[rd_a] : '0;     // display side
                if (rd_hit)
                    mem[rd_a] <= '0;              // clear behind the read
            end
        end
    end

    assign pxl = rd_sel ? g_half[1].q : g_half[0].q;

    // a write still pending at the swap would land in the shown half
    a_no_wr_at_swap: assert property (@(posedge clk) disable iff (rst)
        line_start |-> !wr_en)
        else $error("line buffer write collides with half swap");

endmodule

//--- hdl/regs_pkg.sv
// register map of the scroll layer cpu port
// apb with a 4-bit byte address, registers are 16 bits wide
// status is read only, a write there is flagged with pslverr
package regs_pkg;

    localparam int apb_aw = 4;    // byte address bits
    localparam int reg_w  = 16;   // register and bus data width

    // byte offsets
    localparam logic [apb_aw-1:0] reg_pages  = 4'd0;
    localparam logic [apb_aw-1:0] reg_hscr   = 4'd4;
    localparam logic [apb_aw-1:0] reg_vscr   = 4'd8;
    localparam logic [apb_aw-1:0] reg_status = 4'd12;

    // status fields
    localparam int status_busy_bit = 0;

endpackage

//--- hdl/scroll_decode.sv
`timescale 1ns/1ps
// screen position to map address, purely combinational
// h wraps at 1024 and v at 512; bit 9 of h and bit 8 of v pick
// the quadrant, which selects one 3-bit page field of the pages word
// only the low bits of hscr and vscr are used
module scroll_decode
    import video_pkg::*;
    import regs_pkg::*;
(
    input  logic [pos_w-1:0]      col,
    input  logic [pos_w-1:0]      line,
    input  logic [reg_w-1:0]      pages_q,
    input  logic [reg_w-1:0]      hscr_q,
    input  logic [reg_w-1:0]      vscr_q,
    output logic [map_addr_w-1:0] map_addr_next,
    output logic [tile_sh-1:0]    tile_row,
    output logic [tile_sh-1:0]    tile_col
);

    logic [pos_w:0]   h;     // 10 bits, wraps at 1024
    logic [pos_w-1:0] v;     // 9 bits, wraps at 512
    logic [2:0]       page;

    always_comb begin
        h = {1'b0, col} + hscr_q[pos_w:0];
        v = line + vscr_q[pos_w-1:0];
        // v[8] set means bottom half, h[9] set means right half
        case ({v[pos_w-1], h[pos_w]})
            2'b00:   page = pages_q[14:12];  // top-left
            2'b01:   page = pages_q[10:8];   // top-right
            2'b10:   page = pages_q[6:4];    // bottom-left
            default: page = pages_q[2:0];    // bottom-right
        endcase
    end

    // page, tile row within page, tile column within page
    assign map_addr_next = {page, v[7:tile_sh], h[8:tile_sh]};
    assign tile_row      = v[tile_sh-1:0];
    assign tile_col      = h[tile_sh-1:0];  // first pixel inside the tile

endmodule

//--- hdl/scroll_layer.sv
`timescale 1ns/1ps
// single background scroll layer
// cpu side: zero-wait apb with pages, hscr, vscr and status
// rom side: map and tile ports with req/ok handshakes
// pixels are rendered one per clk, no pixel clock enable
// line_w up to 2**buf_aw pixels per line
module scroll_layer
    import video_pkg::*;
    import regs_pkg::*;
#(
    parameter int line_w = 256,
    parameter int buf_aw = 9
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [apb_aw-1:0]      paddr,
    input  logic [reg_w-1:0]       pwdata,
    output logic [reg_w-1:0]       prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   lhbl,
    input  logic [pos_w-1:0]       vrender,
    input  logic [pos_w-1:0]       hdump,
    output logic [pxl_w-1:0]       pxl,
    output logic                   map_req,
    output logic [map_addr_w-1:0]  map_addr,
    input  logic                   map_ok,
    input  logic [map_dw-1:0]      map_data,
    output logic                   tile_req,
    output logic [tile_addr_w-1:0] tile_addr,
    input  logic                   tile_ok,
    input  logic [tile_dw-1:0]     tile_data
);

    logic                  line_start;
    logic                  busy;
    logic [reg_w-1:0]      pages_q;
    logic [reg_w-1:0]      hscr_q;
    logic [reg_w-1:0]      vscr_q;
    logic [pos_w-1:0]      line;
    logic [pos_w-1:0]      col;
    logic [map_addr_w-1:0] map_addr_next;
    logic [tile_sh-1:0]    tile_row;
    logic [tile_sh-1:0]    tile_col;
    logic                  wr_en;
    logic [buf_aw-1:0]     wr_addr;
    logic [pxl_w-1:0]      wr_data;

    scroll_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .line_start (line_start),
        .busy       (busy),
        .pages_q    (pages_q),
        .hscr_q     (hscr_q),
        .vscr_q     (vscr_q)
    );

    // decode stage
    scroll_decode u_decode (
        .col           (col),
        .line          (line),
        .pages_q       (pages_q),
        .hscr_q        (hscr_q),
        .vscr_q        (vscr_q),
        .map_addr_next (map_addr_next),
        .tile_row      (tile_row),
        .tile_col      (tile_col)
    );

    // execute stage, rom traffic and pixel shifting
    tile_fetch #(
        .line_w (line_w),
        .buf_aw (buf_aw)
    ) u_fetch (
        .clk           (clk),
        .rst           (rst),
        .lhbl          (lhbl),
        .vrender       (vrender),
        .line_start    (line_start),
        .line          (line),
        .busy          (busy),
        .col           (col),
        .map_addr_next (map_addr_next),
        .tile_row      (tile_row),
        .tile_col      (tile_col),
        .map_req       (map_req),
        .map_addr      (map_addr),
        .map_ok        (map_ok),
        .map_data      (map_data),
        .tile_req      (tile_req),
        .tile_addr     (tile_addr),
        .tile_ok       (tile_ok),
        .tile_data     (tile_data),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    // result stage
    line_buffer #(
        .line_w (line_w),
        .buf_aw (buf_aw),
        .dw     (pxl_w)
    ) u_linebuf (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .hdump      (hdump),
        .pxl        (pxl)
    );

endmodule

//--- hdl/scroll_regs.sv
`timescale 1ns/1ps
// apb slave for the scroll layer, zero wait states
// live registers are written in the access phase and copied to the
// shadow outputs on line_start, so a write only shows on the next line
// read data is combinational and only valid during access
module scroll_regs
    import regs_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_aw-1:0] paddr,
    input  logic [reg_w-1:0]  pwdata,
    output logic [reg_w-1:0]  prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              line_start,
    input  logic              busy,
    output logic [reg_w-1:0]  pages_q,
    output logic [reg_w-1:0]  hscr_q,
    output logic [reg_w-1:0]  vscr_q
);

    logic [reg_w-1:0] pages_r;  // live copies
    logic [reg_w-1:0] hscr_r;
    logic [reg_w-1:0] vscr_r;
    logic [reg_w-1:0] status_w;
    logic             access;
    logic             mapped;

    assign access = psel & penable;
    assign mapped = (paddr == reg_pages) || (paddr == reg_hscr) ||
                    (paddr == reg_vscr) || (paddr == reg_status);
    assign pready = 1'b1;  // never stalls

    // bad offset, or a write to the read-only status
    assign pslverr = access & (~mapped | (pwrite & (paddr == reg_status)));

    always_comb begin
        status_w = '0;
        status_w[status_busy_bit] = busy;
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                reg_pages:  prdata = pages_r;
                reg_hscr:   prdata = hscr_r;
                reg_vscr:   prdata = vscr_r;
                reg_status: prdata = status_w;
                default:    prdata = '0;  // unmapped reads as zero
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pages_r <= '0;
            hscr_r  <= '0;
            vscr_r  <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                reg_pages: pages_r <= pwdata;
                reg_hscr:  hscr_r  <= pwdata;
                reg_vscr:  vscr_r  <= pwdata;
                default: ;  // status and holes ignore writes
            endcase
        end
    end

    // shadow copy, taken once per line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pages_q <= '0;
            hscr_q  <= '0;
            vscr_q  <= '0;
        end else if (line_start) begin
            pages_q <= pages_r;
            hscr_q  <= hscr_r;
            vscr_q  <= vscr_r;
        end
    end

    // access phase must follow a setup phase with psel held
    a_penable_psel: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> psel)
        else $error("penable rose without psel");

endmodule

//--- hdl/tile_fetch.sv
`timescale 1ns/1ps
// renders one line into the line buffer after each lhbl fall
// each tile takes one map read and one tile read, then a pixel per clk
// rom latency only stretches the line
// busy stays high until the last column is written
// and that write lands one clk later
// a new lhbl fall while busy drops the current line and restarts
module tile_fetch
    import video_pkg::*;
#(
    parameter int line_w = 256,
    parameter int buf_aw = 9
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lhbl,
    input  logic [pos_w-1:0]       vrender,
    output logic                   line_start,
    output logic [pos_w-1:0]       line,
    output logic                   busy,
    output logic [pos_w-1:0]       col,
    input  logic [map_addr_w-1:0]  map_addr_next,
    input  logic [tile_sh-1:0]     tile_row,
    input  logic [tile_sh-1:0]     tile_col,
    output logic                   map_req,
    output logic [map_addr_w-1:0]  map_addr,
    input  logic                   map_ok,
    input  logic [map_dw-1:0]      map_data,
    output logic                   tile_req,
    output logic [tile_addr_w-1:0] tile_addr,
    input  logic                   tile_ok,
    input  logic [tile_dw-1:0]     tile_data,
    output logic                   wr_en,
    output logic [buf_aw-1:0]      wr_addr,
    output logic [pxl_w-1:0]       wr_data
);

    typedef enum logic [1:0] {st_idle, st_map, st_tile, st_shift} state_t;

    state_t             state;
    logic               lhbl_l;
    logic               fall;
    logic               last_col;
    logic               issue_map;
    logic               map_done;
    logic               tile_done;
    logic [tile_sh-1:0] px;        // column inside current tile
    logic [attr_w-1:0]  attr;
    logic [7:0]         pl0;       // bit planes with the leftmost pixel at bit 7
    logic [7:0]         pl1;
    logic [7:0]         pl2;

    assign fall     = lhbl_l & ~lhbl;
    assign last_col = col == pos_w'(line_w - 1);

    // wait out the line_start cycle while the shadows update
    assign issue_map = (state == st_map) && !map_req && !line_start;
    assign map_done  = map_req & map_ok;
    assign tile_done = tile_req & tile_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            lhbl_l     <= 1'b0;
            line_start <= 1'b0;
            busy       <= 1'b0;
            col        <= '0;
            px         <= '0;
            map_req    <= 1'b0;
            tile_req   <= 1'b0;
            wr_en      <= 1'b0;
        end else begin
            lhbl_l     <= lhbl;
            line_start <= fall;
            wr_en      <= 1'b0;
            if (fall) begin  // also the abort path
                state    <= st_map;
                busy     <= 1'b1;
                col      <= '0;
                map_req  <= 1'b0;
                tile_req <= 1'b0;
            end else begin
                case (state)
                    st_map: begin
                        if (issue_map) begin
                            map_req <= 1'b1;
                        end else if (map_done) begin
                            map_req  <= 1'b0;
                            tile_req <= 1'b1;  // tile address latched with it
                            state    <= st_tile;
                        end
                    end
                    st_tile: begin
                        if (tile_done) begin
                            tile_req <= 1'b0;
                            px       <= tile_col;  // mid-tile start on first tile
                            state    <= st_shift;
                        end
                    end
                    st_shift: begin
                        wr_en <= 1'b1;
                        col   <= col + 1'b1;
                        px    <= px + 1'b1;
                        if (last_col) begin
                            state <= st_idle;
                            busy  <= 1'b0;
                        end else if (&px) begin
                            state <= st_map;  // next tile
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (fall)
            line <= vrender;
        if (issue_map)
            map_addr <= map_addr_next;
        if (map_done) begin
            attr      <= map_data[12:5];
            tile_addr <= {map_data[13], map_data[code_w-1:0], tile_row, 1'b0};
        end
        if (tile_done) begin
            // drop the pixels left of the start column
            pl0 <= tile_data[7:0] << tile_col;
            pl1 <= tile_data[15:8] << tile_col;
            pl2 <= tile_data[23:16] << tile_col;
        end else if (state == st_shift) begin
            pl0 <= pl0 << 1;
            pl1 <= pl1 << 1;
            pl2 <= pl2 << 1;
        end
        if (state == st_shift) begin
            wr_addr <= buf_aw'(col);
            wr_data <= {attr, pl2[7], pl1[7], pl0[7]};
        end
    end

    // rom address held until ok
    a_map_stable: assert property (@(posedge clk) disable iff (rst)
        map_req && !map_ok |=> $stable(map_addr))
        else $error("map_addr changed while waiting for map_ok");

    a_tile_stable: assert property (@(posedge clk) disable iff (rst)
        tile_req && !tile_ok |=> $stable(tile_addr))
        else $error("tile_addr changed while waiting for tile_ok");

    a_wr_range: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> int'(wr_addr) < line_w)
        else $error("write past the end of the line");

endmodule

//--- hdl/video_pkg.sv
// geometry shared by the tile scroll layer
// tiles are 8x8 pixels with 3 bit planes, map pages are 64x32 tiles
// map rom is word addressed, tile rom holds 32-bit rows (planes in bytes 0..2)
// the line coordinate width also bounds the rendered line length
package video_pkg;

    // screen coordinates, vrender and hdump
    localparam int pos_w = 9;

    // tile size as a shift, 8 pixels per side
    localparam int tile_sh = 3;

    // map rom: 3-bit page, 5-bit tile row, 6-bit tile column
    localparam int map_addr_w = 14;
    localparam int map_dw     = 16;   // map word width

    // tile rom: bank, code, tile row, one zero bit
    localparam int code_w      = 12;
    localparam int tile_addr_w = 1 + code_w + tile_sh + 1;
    localparam int tile_dw     = 32;  // one row, three planes plus a spare byte

    // pixel = attribute, then colour bits 2..0
    localparam int attr_w = 8;
    localparam int pxl_w  = attr_w + tile_sh;

endpackage

//--- list.f
hdl/video_pkg.sv
hdl/regs_pkg.sv
hdl/scroll_regs.sv
hdl/scroll_decode.sv
hdl/tile_fetch.sv
hdl/line_buffer.sv
hdl/scroll_layer.sv
bench/scroll_layer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the scroll layer testbench with verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f list.f --top-module scroll_layer_tb -o sim \
    && ./obj_dir/sim | tee /dev/stderr | grep -q "Test completed successfully" \
    || exit 1
